// File: common/mem_if.sv
`timescale 1ns/1ps
`include "sb_cfg.svh"

// write and read ports of the fifo storage
interface mem_if import sb_pkg::*; ();

   logic  wr_en;    // write strobe
   addr_t wr_addr;  // write entry
   data_t wr_data;  // write word
   logic  rd_en;    // load read register
   addr_t rd_addr;  // read entry
   data_t rd_data;  // registered, valid cycle after rd_en

   // pointer side
   modport ctrl (
      output wr_en, wr_addr, wr_data,
      output rd_en, rd_addr,
      input  rd_data
   );

   // storage side
   modport array (
      input  wr_en, wr_addr, wr_data,
      input  rd_en, rd_addr,
      output rd_data
   );

endinterface

// File: common/sb_cfg.svh
`ifndef SB_CFG_SVH
`define SB_CFG_SVH

// channel word width
`define SB_DATA_W     16

// fifo geometry, depth must stay a power of two
`define SB_DEPTH      8
`define SB_ADDR_W     3

// prog_full threshold in entries
`define SB_PROG_FULL  6

`endif

// File: common/sb_pkg.sv
`include "sb_cfg.svh"

package sb_pkg;

   //############################
   // vector types
   //############################
   typedef logic [`SB_DATA_W-1:0] data_t;   // one channel word
   typedef logic [`SB_ADDR_W-1:0] addr_t;   // memory entry address
   typedef logic [`SB_ADDR_W:0]   ptr_t;    // address plus wrap bit
   typedef logic [`SB_ADDR_W:0]   count_t;  // occupancy 0..depth

   //############################
   // handshake fsm states
   //############################
   // receiver, one push per transfer
   typedef enum logic {RX_IDLE, RX_ACK} rx_state_t;

   // sender, pop then wait for registered read data
   typedef enum logic [2:0] {TX_IDLE, TX_FETCH, TX_LOAD, TX_REQ, TX_DROP} tx_state_t;

endpackage

// File: fifo/sb_fifo_ctrl.sv
`timescale 1ns/1ps
`include "sb_cfg.svh"

module sb_fifo_ctrl import sb_pkg::*; (
   input  logic   clk,
   input  logic   nreset,
   input  logic   clear,        // sync flush of pointers and count
   // write side
   input  logic   push,
   input  data_t  push_data,
   output logic   full,
   // read side
   input  logic   pop,
   output logic   empty,
   output data_t  pop_data,     // valid cycle after pop
   // status
   output count_t count,
   output logic   almost_full,
   output logic   prog_full
);

   ptr_t   wr_ptr;     // write pointer, msb is wrap
   ptr_t   rd_ptr;     // read pointer, msb is wrap
   count_t count_q;    // occupancy
   logic   do_push;    // accepted write
   logic   do_pop;     // accepted read
   logic   ptr_match;  // same entry on both pointers

   //############################
   // flags
   //############################
   assign do_push   = push & ~full;
   assign do_pop    = pop & ~empty;
   assign ptr_match = (wr_ptr[`SB_ADDR_W-1:0] == rd_ptr[`SB_ADDR_W-1:0]);
   assign full      = ptr_match & (wr_ptr[`SB_ADDR_W] != rd_ptr[`SB_ADDR_W]);  // wrapped once
   assign empty     = ptr_match & (wr_ptr[`SB_ADDR_W] == rd_ptr[`SB_ADDR_W]);

   assign count       = count_q;
   assign almost_full = (count_q == count_t'(`SB_DEPTH - 1));  // one slot left
   assign prog_full   = (count_q >= count_t'(`SB_PROG_FULL));

   //############################
   // pointers and count
   //############################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count_q <= '0;
      end
      else if (clear)
      begin
         // memory and read register keep their contents
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count_q <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= wr_ptr + ptr_t'(1);
         if (do_pop)
            rd_ptr <= rd_ptr + ptr_t'(1);
         // simultaneous push and pop leave count alone
         if (do_push && !do_pop)
            count_q <= count_q + count_t'(1);
         else if (do_pop && !do_push)
            count_q <= count_q - count_t'(1);
      end
   end

   //############################
   // memory
   //############################
   mem_if mem_bus ();

   assign mem_bus.wr_en   = do_push;
   assign mem_bus.wr_addr = wr_ptr[`SB_ADDR_W-1:0];
   assign mem_bus.wr_data = push_data;
   assign mem_bus.rd_en   = do_pop;                  // loads read register
   assign mem_bus.rd_addr = rd_ptr[`SB_ADDR_W-1:0];
   assign pop_data        = mem_bus.rd_data;         // one cycle behind pop

   sb_mem_dp mem_i (
      .clk (clk),
      .mem (mem_bus.array)
   );

   // occupancy bounded by the array
   count_in_range : assert property (
      @(posedge clk) disable iff (!nreset)
      count_q <= count_t'(`SB_DEPTH)
   );

   // overflow attempts are dropped
   no_write_when_full : assert property (
      @(posedge clk) disable iff (!nreset)
      push && full && !clear |=> $stable(wr_ptr)
   );

endmodule

// File: fifo/sb_mem_dp.sv
`timescale 1ns/1ps
`include "sb_cfg.svh"

module sb_mem_dp import sb_pkg::*; (
   input logic clk,
   mem_if.array mem
);

   data_t ram [0:`SB_DEPTH-1];  // storage, no reset
   data_t rd_q;                 // output register

   //############################
   // write port
   //############################
   always_ff @(posedge clk)
   begin
      if (mem.wr_en)
      begin
         ram[mem.wr_addr] <= mem.wr_data;
      end
   end

   //############################
   // read port
   //############################
   // read before write on a shared address, but the fifo flags
   // never allow that case
   always_ff @(posedge clk)
   begin
      if (mem.rd_en)
      begin
         rd_q <= ram[mem.rd_addr];  // held until next rd_en
      end
   end

   assign mem.rd_data = rd_q;

endmodule

// File: files.f
+incdir+common
common/sb_pkg.sv
common/mem_if.sv
fifo/sb_mem_dp.sv
fifo/sb_fifo_ctrl.sv
logic/sb_req_ack_rx.sv
logic/sb_req_ack_tx.sv
logic/sb_buffer_top.sv
tests/tb_sb_buffer.sv

// File: logic/sb_buffer_top.sv
`timescale 1ns/1ps
`include "sb_cfg.svh"

module sb_buffer_top import sb_pkg::*; (
   input  logic   clk,
   input  logic   nreset,
   input  logic   clear,        // sync fifo flush
   // producer handshake
   input  logic   in_req,
   input  data_t  in_data,
   output logic   in_ack,
   // consumer handshake
   output logic   out_req,
   output data_t  out_data,
   input  logic   out_ack,
   // fill status
   output count_t fill_count,
   output logic   almost_full,
   output logic   prog_full,
   output logic   full,
   output logic   empty
);

   logic  push;       // rx -> fifo
   data_t push_data;
   logic  pop;        // tx -> fifo
   data_t pop_data;   // fifo -> tx

   sb_req_ack_rx rx_i (
      .clk       (clk),
      .nreset    (nreset),
      .in_req    (in_req),
      .in_data   (in_data),
      .in_ack    (in_ack),
      .push      (push),
      .push_data (push_data),
      .full      (full)
   );

   sb_fifo_ctrl fifo_i (
      .clk         (clk),
      .nreset      (nreset),
      .clear       (clear),
      .push        (push),
      .push_data   (push_data),
      .full        (full),
      .pop         (pop),
      .empty       (empty),
      .pop_data    (pop_data),
      .count       (fill_count),
      .almost_full (almost_full),
      .prog_full   (prog_full)
   );

   sb_req_ack_tx tx_i (
      .clk      (clk),
      .nreset   (nreset),
      .pop      (pop),
      .empty    (empty),
      .pop_data (pop_data),
      .out_req  (out_req),
      .out_data (out_data),
      .out_ack  (out_ack)
   );

endmodule

// File: logic/sb_req_ack_rx.sv
`timescale 1ns/1ps
`include "sb_cfg.svh"

module sb_req_ack_rx import sb_pkg::*; (
   input  logic  clk,
   input  logic  nreset,
   // producer side
   input  logic  in_req,
   input  data_t in_data,    // stable while in_req high
   output logic  in_ack,
   // fifo side
   output logic  push,
   output data_t push_data,
   input  logic  full
);

   rx_state_t state;
   rx_state_t state_nxt;

   //############################
   // fsm
   //############################
   always_comb
   begin
      state_nxt = state;
      push      = 1'b0;
      unique case (state)
         RX_IDLE:
         begin
            // back-pressure, wait for a free entry
            if (in_req && !full)
            begin
               push      = 1'b1;   // write at this edge
               state_nxt = RX_ACK;
            end
         end
         RX_ACK:
         begin
            if (!in_req)
               state_nxt = RX_IDLE;  // ack drops next cycle
         end
         default: state_nxt = RX_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         state <= RX_IDLE;
      else
         state <= state_nxt;
   end

   assign in_ack    = (state == RX_ACK);  // high once the word is stored
   assign push_data = in_data;

   // ack only answers a request seen the cycle before
   ack_needs_req : assert property (
      @(posedge clk) disable iff (!nreset)
      $rose(in_ack) |-> $past(in_req)
   );

endmodule

// File: logic/sb_req_ack_tx.sv
`timescale 1ns/1ps
`include "sb_cfg.svh"

module sb_req_ack_tx import sb_pkg::*; (
   input  logic  clk,
   input  logic  nreset,
   // fifo side
   output logic  pop,
   input  logic  empty,
   input  data_t pop_data,   // valid cycle after pop
   // consumer side
   output logic  out_req,
   output data_t out_data,
   input  logic  out_ack
);

   tx_state_t state;
   tx_state_t state_nxt;

   //############################
   // fsm
   //############################
   // idle -> fetch -> load -> req -> drop -> idle
   always_comb
   begin
      state_nxt = state;
      pop       = 1'b0;
      unique case (state)
         TX_IDLE:
         begin
            if (!empty)
            begin
               pop       = 1'b1;  // read register loads at this edge
               state_nxt = TX_FETCH;
            end
         end
         TX_FETCH: state_nxt = TX_LOAD;  // pop_data valid here
         TX_LOAD:  state_nxt = TX_REQ;   // out_data settled
         TX_REQ:
         begin
            if (out_ack)
               state_nxt = TX_DROP;     // consumer took the word
         end
         TX_DROP:
         begin
            if (!out_ack)
               state_nxt = TX_IDLE;     // four phases done
         end
         default: state_nxt = TX_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         state <= TX_IDLE;
      else
         state <= state_nxt;
   end

   //############################
   // output word
   //############################
   always_ff @(posedge clk)
   begin
      if (state == TX_FETCH)
         out_data <= pop_data;  // capture registered memory data
   end

   assign out_req = (state == TX_REQ);

   // word held for the whole request phase
   data_held_during_req : assert property (
      @(posedge clk) disable iff (!nreset)
      out_req |-> $stable(out_data)
   );

endmodule

// File: tests/tb_sb_buffer.sv
`timescale 1ns/1ps
`include "sb_cfg.svh"

module tb_sb_buffer import sb_pkg::*; ();

   localparam int n_order      = 20;  // prompt consumer
   localparam int n_bp         = 10;  // nine in flight plus one held off
   localparam int n_cleared    = 5;   // one in the sender, rest flushed
   localparam int n_after      = 3;   // traffic after the flush
   localparam int n_rand       = 40;
   localparam int stall_cycles = 16;  // in_ack must stay low this long
   // about 20 cycles per word, plus reset and stalls
   localparam int timeout_cycles =
      (n_order + n_bp + n_cleared + n_after + n_rand) * 20 + 400;
   localparam logic [31:0] lcg_seed = 32'd67440;

   logic   clk;
   logic   nreset;
   logic   clear;
   logic   in_req;
   data_t  in_data;
   logic   in_ack;
   logic   out_req;
   data_t  out_data;
   logic   out_ack;
   count_t fill_count;
   logic   almost_full;
   logic   prog_full;
   logic   full;
   logic   empty;

   logic [31:0] prod_state;  // producer word stream
   logic [31:0] prod_gap;    // producer delay stream
   logic [31:0] cons_gap;    // consumer delay stream
   int sent_idx;             // words acked by the DUT
   int recv_idx;             // next expected word index
   int occ_model;            // occupancy model
   int errors;
   int test_err_base;
   int tests_failed;
   int cycle_cnt;
   int max_fill;
   logic saw_prog;
   logic saw_almost;
   logic saw_full;
   logic in_ack_d;           // edge detect
   logic out_req_d;

   sb_buffer_top sb_buffer_top_i (
      .clk         (clk),
      .nreset      (nreset),
      .clear       (clear),
      .in_req      (in_req),
      .in_data     (in_data),
      .in_ack      (in_ack),
      .out_req     (out_req),
      .out_data    (out_data),
      .out_ack     (out_ack),
      .fill_count  (fill_count),
      .almost_full (almost_full),
      .prog_full   (prog_full),
      .full        (full),
      .empty       (empty)
   );

   initial clk = 1'b0;
   always #50 clk = ~clk;  // 100 ns period

   //############################
   // reference model
   //############################
   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   // k-th word of the producer stream, rebuilt from the seed
   function automatic data_t word_of(input int k);
      logic [31:0] s;
      int i;
      s = lcg_seed;
      for (i = 0; i <= k; i++)
         s = lcg_next(s);
      return s[31:16];
   endfunction

   function automatic int gap_of(input logic [31:0] s);
      return int'(s[26:24]);  // 0..7 cycles
   endfunction

   //############################
   // check helpers
   //############################
   task automatic expect_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      assert (got === exp)
      else
      begin
         $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
         errors++;
      end
   endtask

   task automatic expect_true(input logic cond, input string what);
      assert (cond)
      else
      begin
         $display("Error: %s", what);
         errors++;
      end
   endtask

   task automatic end_test(input int num, input string name);
      int n;
      n = errors - test_err_base;
      if (n == 0)
         $display("test %0d %s: ok", num, name);
      else
      begin
         $display("test %0d %s: %0d errors", num, name, n);
         tests_failed++;
      end
      test_err_base = errors;
   endtask

   // sender still in drop here, so a leftover word would sit in the fifo
   task automatic check_complete();
      expect_value("empty", empty, 1);
      expect_value("fill_count", fill_count, 0);
   endtask

   //############################
   // handshake drivers
   //############################
   task automatic next_cycle();
      @(posedge clk);
      #5;  // drive and sample after the edge
   endtask

   task automatic start_word();
      prod_state = lcg_next(prod_state);
      in_data    = prod_state[31:16];
      in_req     = 1'b1;
   endtask

   task automatic finish_word();
      do
         next_cycle();
      while (!in_ack);
      in_req = 1'b0;
      do
         next_cycle();
      while (in_ack);  // four phases done
      sent_idx++;
   endtask

   task automatic send_word(input int gap);
      repeat (gap) next_cycle();
      start_word();
      finish_word();
   endtask

   task automatic take_word(input int gap);
      while (!out_req)
         next_cycle();
      repeat (gap) next_cycle();  // consumer think time
      out_ack = 1'b1;
      do
         next_cycle();
      while (out_req);
      out_ack = 1'b0;
   endtask

   //############################
   // output compare and flags
   //############################
   always @(negedge clk)
   begin
      if (nreset)
      begin
         if (out_req && !out_req_d)
         begin
            expect_value($sformatf("out_data[%0d]", recv_idx), out_data, word_of(recv_idx));
            recv_idx++;
            occ_model--;  // word left the fifo
         end
         if (in_ack && !in_ack_d)
            occ_model++;
         if (clear)
            occ_model = 0;  // flushed at the next edge
         // status flags follow the count
         expect_value("full", full, fill_count == count_t'(`SB_DEPTH));
         expect_value("almost_full", almost_full, fill_count == count_t'(`SB_DEPTH - 1));
         expect_value("prog_full", prog_full, fill_count >= count_t'(`SB_PROG_FULL));
         expect_value("empty", empty, fill_count == '0);
         assert (fill_count <= count_t'(`SB_DEPTH))
         else
         begin
            $display("Mismatch fill_count: got 0x%h above depth 0x%h", fill_count, `SB_DEPTH);
            errors++;
         end
         if (int'(fill_count) > max_fill)
            max_fill = int'(fill_count);
         saw_prog   |= prog_full;
         saw_almost |= almost_full;
         saw_full   |= full;
      end
      out_req_d = out_req;
      in_ack_d  = in_ack;
   end

   // run limit
   always @(posedge clk)
   begin
      cycle_cnt++;
      if (cycle_cnt >= timeout_cycles)
      begin
         $display("Error: no finish after %0d cycles, run stopped", cycle_cnt);
         $display("=== FAIL ===");
         $finish;
      end
   end

   //############################
   // test sequence
   //############################
   initial
   begin
      nreset        = 1'b0;
      clear         = 1'b0;
      in_req        = 1'b0;
      in_data       = '0;
      out_ack       = 1'b0;
      prod_state    = lcg_seed;
      prod_gap      = lcg_seed ^ 32'h0001_0000;  // own stream per side
      cons_gap      = lcg_seed ^ 32'h0002_0000;
      sent_idx      = 0;
      recv_idx      = 0;
      occ_model     = 0;
      errors        = 0;
      test_err_base = 0;
      tests_failed  = 0;
      cycle_cnt     = 0;
      max_fill      = 0;
      saw_prog      = 1'b0;
      saw_almost    = 1'b0;
      saw_full      = 1'b0;
      in_ack_d      = 1'b0;
      out_req_d     = 1'b0;
      repeat (10) @(posedge clk);
      #5;
      nreset = 1'b1;

      // values straight out of reset
      expect_value("in_ack", in_ack, 0);
      expect_value("out_req", out_req, 0);
      expect_value("full", full, 0);
      expect_value("almost_full", almost_full, 0);
      expect_value("prog_full", prog_full, 0);
      expect_value("empty", empty, 1);
      expect_value("fill_count", fill_count, 0);
      end_test(1, "reset values");

      fork
         repeat (n_order) send_word(0);
         repeat (n_order) take_word(0);
      join
      check_complete();
      end_test(2, "order and data");

      // consumer stalled, fill to the brim
      saw_prog   = 1'b0;
      saw_almost = 1'b0;
      saw_full   = 1'b0;
      max_fill   = 0;
      repeat (n_bp - 1) send_word(0);
      start_word();
      repeat (stall_cycles)
      begin
         next_cycle();
         expect_value("in_ack", in_ack, 0);  // held off while full
      end
      expect_value("fill_count", fill_count, `SB_DEPTH);
      expect_value("fill_count", fill_count, occ_model);
      expect_value("out_req", out_req, 1);  // sender holds one word
      fork
         finish_word();
         repeat (n_bp) take_word(0);
      join
      expect_true(saw_prog, "prog_full never seen while filling");
      expect_true(saw_almost, "almost_full never seen while filling");
      expect_true(saw_full, "full never seen while filling");
      expect_value("max fill_count", max_fill, `SB_DEPTH);
      check_complete();
      end_test(3, "back-pressure");

      // flush with words stored
      repeat (n_cleared) send_word(0);
      while (!out_req)
         next_cycle();
      expect_value("fill_count", fill_count, occ_model);
      expect_value("fill_count", fill_count, n_cleared - 1);
      clear = 1'b1;
      next_cycle();
      clear = 1'b0;
      expect_value("empty", empty, 1);
      expect_value("fill_count", fill_count, 0);
      take_word(0);  // word already in the sender
      repeat (8)
      begin
         next_cycle();
         expect_value("out_req", out_req, 0);  // nothing stale follows
      end
      recv_idx = sent_idx;  // flushed words never arrive
      fork
         repeat (n_after) send_word(0);
         repeat (n_after) take_word(0);
      join
      check_complete();
      end_test(4, "clear");

      fork
         repeat (n_rand)
         begin
            prod_gap = lcg_next(prod_gap);
            send_word(gap_of(prod_gap));
         end
         repeat (n_rand)
         begin
            cons_gap = lcg_next(cons_gap);
            take_word(gap_of(cons_gap));
         end
      join
      check_complete();
      end_test(5, "random traffic");

      $display("5 tests, %0d failed, %0d errors", tests_failed, errors);
      if (errors == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule
